// ==== project.f ====
hw/aes_pkg.sv
hw/apb_regmap_pkg.sv
hw/sub_bytes.sv
hw/key_expand.sv
hw/aes_round.sv
hw/aes_apb_feeder.sv
hw/aes_result_buffer.sv
hw/aes_apb_top.sv
testbench/aes_checker.sv
testbench/tb_aes.sv

// ==== Bender.yml ====
package:
  name: aes_apb

sources:
  - hw/aes_pkg.sv
  - hw/apb_regmap_pkg.sv
  - hw/sub_bytes.sv
  - hw/key_expand.sv
  - hw/aes_round.sv
  - hw/aes_apb_feeder.sv
  - hw/aes_result_buffer.sv
  - hw/aes_apb_top.sv
  - target: test
    files:
      - testbench/aes_checker.sv
      - testbench/tb_aes.sv

// ==== testbench/tb_aes.sv ====
`timescale 1ns/1ps

module tb_aes import apb_regmap_pkg::*; ();

   localparam int DEPTH      = 4;
   localparam int NUM_BLOCKS = 1 + 40 + (DEPTH + 1) + 2;   // blocks started by tests 1 to 4
   localparam int MAX_CYCLES = 40 * NUM_BLOCKS + 200;

   logic         clk;
   logic         reset;
   logic         psel;
   logic         penable;
   logic         pwrite;
   logic         pready;
   logic         pslverr;
   logic [7:0]   paddr;
   logic [31:0]  pwdata;
   logic [31:0]  prdata;
   logic [31:0]  rd;
   logic         err;
   logic [127:0] ct;
   logic [127:0] key_b;
   integer       seed;
   int           tb_errors;
   int           chk_errors;
   int           tests_run;
   int           tests_failed;
   int           test_base;
   int           cycles;

   aes_apb_top #(.RESULT_DEPTH(DEPTH)) dut_i (
      .clk     (clk),
      .reset   (reset),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   aes_checker #(.RESULT_DEPTH(DEPTH)) chk_i (
      .clk     (clk),
      .reset   (reset),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .errors  (chk_errors)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
         $display("timeout: the tests did not end within %0d cycles", MAX_CYCLES);
         $display("=== FAIL ===");
         $finish;
      end
   end

   // called on a falling edge, returns on a falling edge with the bus idle
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic perr);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk) penable = 1'b1;
      @(posedge clk) perr = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic perr);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk) penable = 1'b1;
      @(posedge clk);
      data = prdata;
      perr = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   function automatic void check(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
      if (act !== exp) begin
         tb_errors++;
         $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      end
   endfunction

   function automatic logic [127:0] rand128();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   task automatic load_words(input logic [7:0] base, input logic [127:0] value);
      logic perr;
      for (int i = 0; i < 4; i++) apb_write(8'(base + 4 * i), value[127-32*i -: 32], perr);
   endtask

   task automatic start_block(input logic exp_err);
      logic perr;
      apb_write(CTRL, 32'h1, perr);
      check("pslverr on start", exp_err, perr);
   endtask

   task automatic wait_result();
      logic [31:0] status;
      logic        perr;
      status = '0;
      while (!status[0]) begin
         apb_read(STATUS, status, perr);
      end
   endtask

   task automatic read_result(output logic [127:0] value);
      logic [31:0] word;
      logic        perr;
      for (int i = 0; i < 4; i++) begin
         apb_read(8'(RESULT0 + 4 * i), word, perr);
         value[127-32*i -: 32] = word;
      end
   endtask

   task automatic finish_test(input string name);
      int total;
      total = tb_errors + chk_errors;
      tests_run++;
      if (total == test_base) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, name, total - test_base);
      end
      test_base = total;
   endtask

   initial begin
      clk     = 1'b0;
      reset   = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      seed    = 32'hcff3ee33;
      repeat (3) @(posedge clk);
      @(negedge clk) reset = 1'b0;

      load_words(KEY0, 128'h000102030405060708090a0b0c0d0e0f);   // FIPS-197 example
      load_words(DATA0, 128'h00112233445566778899aabbccddeeff);
      start_block(1'b0);
      wait_result();
      read_result(ct);
      check("ciphertext", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, ct);
      finish_test("known answer");

      repeat (40) begin
         load_words(KEY0, rand128());
         load_words(DATA0, rand128());
         start_block(1'b0);
         wait_result();
         read_result(ct);
      end
      finish_test("random blocks");

      load_words(KEY0, rand128());
      repeat (DEPTH) begin
         load_words(DATA0, rand128());
         start_block(1'b0);
      end
      start_block(1'b1);                          // no credit left
      wait_result();
      read_result(ct);
      start_block(1'b0);
      repeat (DEPTH) begin
         wait_result();
         read_result(ct);
      end
      finish_test("pipelined burst");

      load_words(KEY0, rand128());
      load_words(DATA0, rand128());
      start_block(1'b0);
      apb_write(KEY0, $random(seed), err);
      check("pslverr on KEY0 in flight", 1'b1, err);
      wait_result();
      apb_write(KEY1, $random(seed), err);
      check("pslverr on KEY1 buffered", 1'b1, err);
      read_result(ct);
      key_b = rand128();
      load_words(KEY0, key_b);
      apb_read(KEY0, rd, err);
      check("KEY0", key_b[127:96], rd);
      start_block(1'b0);
      wait_result();
      read_result(ct);
      finish_test("key lock");

      apb_read(RESULT0, rd, err);
      check("pslverr on empty RESULT0", 1'b1, err);
      apb_read(8'h28, rd, err);
      check("pslverr on read of 28", 1'b1, err);
      apb_write(8'h40, 32'h1, err);
      check("pslverr on write of 40", 1'b1, err);
      apb_read(STATUS, rd, err);
      check("STATUS", 32'h0, rd);
      finish_test("error cases");

      $display("tests run %0d, tests failed %0d, errors %0d",
               tests_run, tests_failed, tb_errors + chk_errors);
      if (tb_errors + chk_errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== testbench/aes_checker.sv ====
`timescale 1ns/1ps

module aes_checker import aes_pkg::*, apb_regmap_pkg::*; #(
   parameter int RESULT_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [APB_ADDR_W-1:0] paddr,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [WORD_W-1:0]     pwdata,
   input  logic [WORD_W-1:0]     prdata,
   input  logic                  pready,
   input  logic                  pslverr,
   output int                    errors
);

   logic [7:0]         sbox_tab [256];
   logic [BLOCK_W-1:0] key_m;
   logic [BLOCK_W-1:0] data_m;
   logic [BLOCK_W-1:0] exp_q [$];        // expected ciphertexts in start order
   int unsigned        start_cyc [$];
   int unsigned        cycle;

   function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
      logic [7:0] p;
      p = 8'h00;
      for (int i = 0; i < 8; i++) begin
         if (b[0]) p = p ^ a;
         a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
         b = b >> 1;
      end
      return p;
   endfunction

   function automatic void compare(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
      if (act !== exp) begin
         errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endfunction

   // brute force inverse, then the affine map
   initial begin : build_sbox
      logic [7:0] inv;
      logic [7:0] s;
      for (int x = 0; x < 256; x++) begin
         inv = 8'h00;                         // zero maps to zero
         for (int y = 1; y < 256; y++) begin
            if (gmul(8'(x), 8'(y)) == 8'h01) inv = 8'(y);
         end
         for (int i = 0; i < 8; i++) begin
            s[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8];
         end
         sbox_tab[x] = s ^ 8'h63;
      end
   end

   function automatic logic [127:0] encrypt(input logic [127:0] key, input logic [127:0] pt);
      logic [31:0]  w [44];
      logic [31:0]  t;
      logic [7:0]   rc;
      logic [7:0]   s [16];
      logic [7:0]   n [16];
      logic [127:0] st;
      rc = 8'h01;
      for (int i = 0; i < 4; i++) w[i] = key[127-32*i -: 32];
      for (int i = 4; i < 44; i++) begin
         t = w[i-1];
         if (i % 4 == 0) begin
            t = {sbox_tab[t[23:16]], sbox_tab[t[15:8]], sbox_tab[t[7:0]], sbox_tab[t[31:24]]}
              ^ {rc, 24'h000000};
            rc = gmul(rc, 8'h02);
         end
         w[i] = w[i-4] ^ t;
      end
      st = pt ^ {w[0], w[1], w[2], w[3]};
      for (int r = 1; r <= NUM_ROUNDS; r++) begin
         for (int k = 0; k < 16; k++) s[k] = sbox_tab[st[127-8*k -: 8]];
         for (int k = 0; k < 16; k++) n[k] = s[4*((k/4 + k%4) % 4) + k%4];   // shift rows
         for (int k = 0; k < 16; k++) begin
            if (r < NUM_ROUNDS) begin
               s[k] = gmul(n[k], 8'h02) ^ gmul(n[4*(k/4) + (k+1)%4], 8'h03)
                    ^ n[4*(k/4) + (k+2)%4] ^ n[4*(k/4) + (k+3)%4];
            end else begin
               s[k] = n[k];
            end
         end
         for (int k = 0; k < 16; k++) st[127-8*k -: 8] = s[k] ^ w[4*r + k/4][31-8*(k%4) -: 8];
      end
      return st;
   endfunction

   always @(posedge clk) begin : watch
      logic         exp_err;
      logic [31:0]  exp_word;
      logic [127:0] head;
      int           n_ready;
      int           outstanding;
      if (reset) begin
         exp_q.delete();
         start_cyc.delete();
         key_m  = '0;
         data_m = '0;
      end else if (psel && penable) begin
         n_ready = 0;
         for (int i = 0; i < start_cyc.size(); i++) begin
            if (cycle > start_cyc[i] + 12) n_ready++;    // visible 12 cycles after start
         end
         outstanding = start_cyc.size();
         exp_err = !(paddr inside {KEY0, KEY1, KEY2, KEY3, DATA0, DATA1, DATA2, DATA3, CTRL,
                                   STATUS, RESULT0, RESULT1, RESULT2, RESULT3})
                 || (pwrite && paddr == CTRL && pwdata[0] && outstanding >= RESULT_DEPTH)
                 || (pwrite && paddr inside {KEY0, KEY1, KEY2, KEY3} && outstanding != 0)
                 || (!pwrite && paddr inside {RESULT0, RESULT1, RESULT2, RESULT3}
                     && n_ready == 0);
         if (pslverr !== exp_err) begin
            errors++;
            $display("** Error at %0t: pslverr at offset %h expected %b, got %b",
                     $time, paddr, exp_err, pslverr);
         end
         compare("pready", 32'h1, 32'(pready));         // no wait states
         if (!exp_err && pwrite) begin
            if (paddr inside {KEY0, KEY1, KEY2, KEY3}) key_m[127-32*paddr[3:2] -: 32] = pwdata;
            if (paddr inside {DATA0, DATA1, DATA2, DATA3}) begin
               data_m[127-32*paddr[3:2] -: 32] = pwdata;
            end
            if (paddr == CTRL && pwdata[0]) begin
               exp_q.push_back(encrypt(key_m, data_m));
               start_cyc.push_back(cycle);
            end
         end else if (!exp_err && paddr == STATUS) begin
            exp_word        = 32'h0;
            exp_word[0]     = (n_ready != 0);
            exp_word[11:8]  = 4'(outstanding - n_ready);
            exp_word[15:12] = 4'(n_ready);
            compare("STATUS", exp_word, prdata);
         end else if (!exp_err && paddr inside {RESULT0, RESULT1, RESULT2, RESULT3}) begin
            head = exp_q[0];
            compare($sformatf("RESULT%0d", paddr[3:2]), head[127-32*paddr[3:2] -: 32], prdata);
            if (paddr == RESULT3) begin
               void'(exp_q.pop_front());
               void'(start_cyc.pop_front());
            end
         end
      end
      cycle++;
   end

endmodule

// ==== hw/aes_apb_top.sv ====
`timescale 1ns/1ps

module aes_apb_top import aes_pkg::*, apb_regmap_pkg::*; #(
   parameter int RESULT_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [APB_ADDR_W-1:0] paddr,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [WORD_W-1:0]     pwdata,
   output logic [WORD_W-1:0]     prdata,
   output logic                  pready,
   output logic                  pslverr
);

   localparam int CNT_W = $clog2(RESULT_DEPTH + 1);

   logic               stage_valid [NUM_ROUNDS+1];   // index 0 is the feeder output
   logic [BLOCK_W-1:0] stage_state [NUM_ROUNDS+1];
   logic [BLOCK_W-1:0] round_key   [NUM_ROUNDS+1];
   logic [BLOCK_W-1:0] cipher_key;
   logic [BLOCK_W-1:0] res_data;
   logic [CNT_W-1:0]   res_count;
   logic               res_pop;

   aes_apb_feeder #(.RESULT_DEPTH(RESULT_DEPTH)) feeder_i (
      .clk         (clk),
      .reset       (reset),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .round_key_0 (round_key[0]),
      .cipher_key  (cipher_key),
      .in_valid    (stage_valid[0]),
      .in_state    (stage_state[0]),
      .out_valid   (stage_valid[NUM_ROUNDS]),
      .res_data    (res_data),
      .res_count   (res_count),
      .res_pop     (res_pop)
   );

   key_expand key_expand_i (
      .cipher_key   (cipher_key),
      .round_key_0  (round_key[0]),
      .round_key_1  (round_key[1]),
      .round_key_2  (round_key[2]),
      .round_key_3  (round_key[3]),
      .round_key_4  (round_key[4]),
      .round_key_5  (round_key[5]),
      .round_key_6  (round_key[6]),
      .round_key_7  (round_key[7]),
      .round_key_8  (round_key[8]),
      .round_key_9  (round_key[9]),
      .round_key_10 (round_key[10])
   );

   for (genvar r = 1; r <= NUM_ROUNDS; r++) begin : gen_round
      aes_round #(.FINAL(r == NUM_ROUNDS)) round_i (    // last round skips MixColumns
         .clk       (clk),
         .reset     (reset),
         .valid_in  (stage_valid[r-1]),
         .state_in  (stage_state[r-1]),
         .round_key (round_key[r]),
         .valid_out (stage_valid[r]),
         .state_out (stage_state[r])
      );
   end

   aes_result_buffer #(.RESULT_DEPTH(RESULT_DEPTH)) result_buffer_i (
      .clk       (clk),
      .reset     (reset),
      .out_valid (stage_valid[NUM_ROUNDS]),
      .out_state (stage_state[NUM_ROUNDS]),
      .res_pop   (res_pop),
      .res_data  (res_data),
      .res_count (res_count)
   );

endmodule

// ==== hw/aes_result_buffer.sv ====
`timescale 1ns/1ps

module aes_result_buffer import aes_pkg::*; #(
   parameter  int RESULT_DEPTH = 4,
   localparam int CNT_W        = $clog2(RESULT_DEPTH + 1),
   localparam int PTR_W        = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               out_valid,
   input  logic [BLOCK_W-1:0] out_state,
   input  logic               res_pop,
   output logic [BLOCK_W-1:0] res_data,
   output logic [CNT_W-1:0]   res_count
);

   logic [BLOCK_W-1:0] mem [RESULT_DEPTH];
   logic [PTR_W-1:0]   wr_ptr, rd_ptr;
   logic               pop_en;

   assign pop_en   = res_pop && (res_count != '0);
   assign res_data = mem[rd_ptr];      // head entry

   always_ff @(posedge clk) begin
      if (out_valid) mem[wr_ptr] <= out_state;   // credit rule keeps a slot free
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         res_count <= '0;
      end else begin
         if (out_valid) wr_ptr <= (wr_ptr == PTR_W'(RESULT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop_en) rd_ptr <= (rd_ptr == PTR_W'(RESULT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({out_valid, pop_en})
            2'b10: res_count <= res_count + 1'b1;
            2'b01: res_count <= res_count - 1'b1;
            default: ;
         endcase
      end
   end

endmodule

// ==== hw/aes_apb_feeder.sv ====
`timescale 1ns/1ps

module aes_apb_feeder import aes_pkg::*, apb_regmap_pkg::*; #(
   parameter  int RESULT_DEPTH = 4,
   localparam int CNT_W        = $clog2(RESULT_DEPTH + 1)
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [APB_ADDR_W-1:0] paddr,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [WORD_W-1:0]     pwdata,
   output logic [WORD_W-1:0]     prdata,
   output logic                  pready,
   output logic                  pslverr,
   input  logic [BLOCK_W-1:0]    round_key_0,
   output logic [BLOCK_W-1:0]    cipher_key,
   output logic                  in_valid,
   output logic [BLOCK_W-1:0]    in_state,
   input  logic                  out_valid,
   input  logic [BLOCK_W-1:0]    res_data,
   input  logic [CNT_W-1:0]      res_count,
   output logic                  res_pop
);

   aes_reg_e           reg_sel;
   logic               access, wr_en, rd_en, mapped;
   logic               key_wr, data_wr, result_rd, start_req, start_ok;
   logic               key_locked, credit_ok, start_q;
   logic [1:0]         word_sel;          // word 0 is the top of the block
   logic [CNT_W-1:0]   in_flight;
   logic [BLOCK_W-1:0] key_q, data_q;

   assign reg_sel  = aes_reg_e'(paddr);
   assign word_sel = ~paddr[3:2];
   assign access   = psel && penable;
   assign wr_en    = access && pwrite;
   assign rd_en    = access && !pwrite;

   always_comb begin
      case (reg_sel)
         KEY0, KEY1, KEY2, KEY3, DATA0, DATA1, DATA2, DATA3, CTRL, STATUS,
         RESULT0, RESULT1, RESULT2, RESULT3: mapped = 1'b1;
         default: mapped = 1'b0;
      endcase
   end

   assign key_wr     = wr_en && (reg_sel inside {KEY0, KEY1, KEY2, KEY3});
   assign data_wr    = wr_en && (reg_sel inside {DATA0, DATA1, DATA2, DATA3});
   assign result_rd  = rd_en && (reg_sel inside {RESULT0, RESULT1, RESULT2, RESULT3});
   assign start_req  = wr_en && (reg_sel == CTRL) && pwdata[0];
   assign key_locked = (in_flight != '0) || (res_count != '0);   // round keys not pipelined
   assign credit_ok  = ({1'b0, in_flight} + {1'b0, res_count}) < (CNT_W + 1)'(RESULT_DEPTH);
   assign start_ok   = start_req && credit_ok;
   assign res_pop    = result_rd && (reg_sel == RESULT3) && (res_count != '0);

   assign pready  = 1'b1;
   assign pslverr = access && (!mapped || (start_req && !credit_ok) || (key_wr && key_locked)
                               || (result_rd && res_count == '0));

   assign cipher_key = key_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         key_q     <= '0;
         data_q    <= '0;
         start_q   <= 1'b0;
         in_valid  <= 1'b0;
         in_flight <= '0;
      end else begin
         start_q  <= start_ok;
         in_valid <= start_q;              // one cycle after the start edge
         if (key_wr && !key_locked) key_q[word_sel*WORD_W +: WORD_W] <= pwdata;
         if (data_wr) data_q[word_sel*WORD_W +: WORD_W] <= pwdata;
         case ({start_ok, out_valid})
            2'b10: in_flight <= in_flight + 1'b1;
            2'b01: in_flight <= in_flight - 1'b1;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start_q) in_state <= data_q ^ round_key_0;   // initial AddRoundKey
   end

   always_comb begin
      prdata = '0;
      case (reg_sel)
         KEY0, KEY1, KEY2, KEY3:         prdata = key_q[word_sel*WORD_W +: WORD_W];
         DATA0, DATA1, DATA2, DATA3:     prdata = data_q[word_sel*WORD_W +: WORD_W];
         STATUS: begin
            prdata[0]          = (res_count != '0);
            prdata[8 +: CNT_W]  = in_flight;
            prdata[12 +: CNT_W] = res_count;
         end
         RESULT0, RESULT1, RESULT2, RESULT3: prdata = res_data[word_sel*WORD_W +: WORD_W];
         default: ;
      endcase
   end

endmodule

// ==== hw/aes_round.sv ====
`timescale 1ns/1ps

module aes_round import aes_pkg::*; #(
   parameter bit FINAL = 1'b0
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               valid_in,
   input  logic [BLOCK_W-1:0] state_in,
   input  logic [BLOCK_W-1:0] round_key,
   output logic               valid_out,
   output logic [BLOCK_W-1:0] state_out
);

   logic [7:0]         sb [16];     // byte k sits at bits 127-8k
   logic [7:0]         sr [16];
   logic [7:0]         mc [16];
   logic [BLOCK_W-1:0] next_state;

   for (genvar k = 0; k < 16; k++) begin : gen_sbox
      sub_bytes sbox_i (
         .in_byte  (state_in[BLOCK_W-1-8*k -: 8]),
         .out_byte (sb[k])
      );
   end

   always_comb begin
      logic [7:0] a0, a1, a2, a3;
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            sr[4*c+r] = sb[4*((c+r)%4)+r];          // row r rotates left by r
         end
      end
      for (int c = 0; c < 4; c++) begin
         a0 = sr[4*c];
         a1 = sr[4*c+1];
         a2 = sr[4*c+2];
         a3 = sr[4*c+3];
         mc[4*c]   = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
         mc[4*c+1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
         mc[4*c+2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
         mc[4*c+3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
      end
      for (int k = 0; k < 16; k++) begin
         next_state[BLOCK_W-1-8*k -: 8] = (FINAL ? sr[k] : mc[k])
                                        ^ round_key[BLOCK_W-1-8*k -: 8];
      end
   end

   always_ff @(posedge clk) begin
      state_out <= next_state;
      if (reset) begin
         valid_out <= 1'b0;
      end else begin
         valid_out <= valid_in;
      end
   end

endmodule

// ==== hw/key_expand.sv ====
`timescale 1ns/1ps

module key_expand import aes_pkg::*; (
   input  logic [BLOCK_W-1:0] cipher_key,
   output logic [BLOCK_W-1:0] round_key_0,
   output logic [BLOCK_W-1:0] round_key_1,
   output logic [BLOCK_W-1:0] round_key_2,
   output logic [BLOCK_W-1:0] round_key_3,
   output logic [BLOCK_W-1:0] round_key_4,
   output logic [BLOCK_W-1:0] round_key_5,
   output logic [BLOCK_W-1:0] round_key_6,
   output logic [BLOCK_W-1:0] round_key_7,
   output logic [BLOCK_W-1:0] round_key_8,
   output logic [BLOCK_W-1:0] round_key_9,
   output logic [BLOCK_W-1:0] round_key_10
);

   logic [WORD_W-1:0] w       [4*(NUM_ROUNDS+1)];
   logic [WORD_W-1:0] rot_w   [NUM_ROUNDS];
   logic [WORD_W-1:0] sub_w   [NUM_ROUNDS];

   assign w[0] = cipher_key[127:96];
   assign w[1] = cipher_key[95:64];
   assign w[2] = cipher_key[63:32];
   assign w[3] = cipher_key[31:0];

   for (genvar r = 0; r < NUM_ROUNDS; r++) begin : gen_round
      assign rot_w[r] = {w[4*r+3][23:0], w[4*r+3][31:24]};   // RotWord
      for (genvar b = 0; b < 4; b++) begin : gen_sbox
         sub_bytes sbox_i (
            .in_byte  (rot_w[r][8*b +: 8]),
            .out_byte (sub_w[r][8*b +: 8])
         );
      end
      assign w[4*r+4] = w[4*r] ^ sub_w[r] ^ {rcon(r + 1), 24'h000000};
      assign w[4*r+5] = w[4*r+1] ^ w[4*r+4];
      assign w[4*r+6] = w[4*r+2] ^ w[4*r+5];
      assign w[4*r+7] = w[4*r+3] ^ w[4*r+6];
   end

   assign round_key_0  = {w[0],  w[1],  w[2],  w[3]};
   assign round_key_1  = {w[4],  w[5],  w[6],  w[7]};
   assign round_key_2  = {w[8],  w[9],  w[10], w[11]};
   assign round_key_3  = {w[12], w[13], w[14], w[15]};
   assign round_key_4  = {w[16], w[17], w[18], w[19]};
   assign round_key_5  = {w[20], w[21], w[22], w[23]};
   assign round_key_6  = {w[24], w[25], w[26], w[27]};
   assign round_key_7  = {w[28], w[29], w[30], w[31]};
   assign round_key_8  = {w[32], w[33], w[34], w[35]};
   assign round_key_9  = {w[36], w[37], w[38], w[39]};
   assign round_key_10 = {w[40], w[41], w[42], w[43]};

endmodule

// ==== hw/sub_bytes.sv ====
`timescale 1ns/1ps

module sub_bytes import aes_pkg::*; (
   input  logic [7:0] in_byte,
   output logic [7:0] out_byte
);

   function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
      logic [7:0] p;
      logic [7:0] t;
      p = 8'h00;
      t = a;
      for (int i = 0; i < 8; i++) begin
         if (b[i]) p = p ^ t;
         t = xtime(t);
      end
      return p;
   endfunction

   logic [7:0] pow [8];    // in_byte to the power 2^i
   logic [7:0] inv;

   // x^254 = x^2 * x^4 * ... * x^128, and 0 maps to 0
   always_comb begin
      pow[0] = in_byte;
      for (int i = 1; i < 8; i++) begin
         pow[i] = gf_mul(pow[i-1], pow[i-1]);
      end
      inv = pow[1];
      for (int i = 2; i < 8; i++) begin
         inv = gf_mul(inv, pow[i]);
      end
   end

   assign out_byte = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;   // affine map

endmodule

// ==== hw/apb_regmap_pkg.sv ====
package apb_regmap_pkg;

   localparam int APB_ADDR_W = 8;

   typedef enum logic [APB_ADDR_W-1:0] {
      KEY0    = 8'h00,     // most significant key word
      KEY1    = 8'h04,
      KEY2    = 8'h08,
      KEY3    = 8'h0c,
      DATA0   = 8'h10,
      DATA1   = 8'h14,
      DATA2   = 8'h18,
      DATA3   = 8'h1c,
      CTRL    = 8'h20,     // bit 0 starts a block
      STATUS  = 8'h24,
      RESULT0 = 8'h30,
      RESULT1 = 8'h34,
      RESULT2 = 8'h38,
      RESULT3 = 8'h3c      // reading this one pops the buffer
   } aes_reg_e;

endpackage

// ==== hw/aes_pkg.sv ====
package aes_pkg;

   localparam int BLOCK_W    = 128;
   localparam int WORD_W     = 32;
   localparam int NUM_ROUNDS = 10;

   // multiply by x modulo the AES polynomial
   function automatic logic [7:0] xtime(input logic [7:0] b);
      return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
   endfunction

   // round constant byte for rounds 1 to 10
   function automatic logic [7:0] rcon(input int unsigned round);
      logic [7:0] rc;
      rc = 8'h01;
      for (int unsigned i = 1; i < round; i++) begin
         rc = xtime(rc);                    // 01 02 04 .. 80 1b 36
      end
      return rc;
   endfunction

endpackage
